// ==== spi_pkg.sv ====
/*
 shared widths, word width and FSM state enums for the SPI master
*/
package spi_pkg;

    // received and transmitted word
    parameter int XFER_W = 32;

    // divider select, ratio is 2 ** sel
    parameter int DIV_SEL_W = 3;

    // SCLK edge counter, up to 64 edges per word
    parameter int EDGE_CNT_W = 7;

    typedef enum logic [1:0] {
        W8  = 2'd0,
        W16 = 2'd1,
        W24 = 2'd2,
        W32 = 2'd3
    } data_width_e;

    typedef enum logic [1:0] {
        S_IDLE,
        S_DATA,
        S_END
    } state_e;

endpackage

// ==== spi_clk_div.sv ====
/*
 SCLK half-period timer with power-of-two ratio
*/
`timescale 1ns/1ns

module spi_clk_div #(
    parameter int DIV_CNT_W = 8
) (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    input  logic                          restart_i,
    input  logic                          en_i,
    input  logic [spi_pkg::DIV_SEL_W-1:0] div_ratio_i,
    output logic                          tick_o
);

    logic [DIV_CNT_W-1:0] cnt_q;
    logic [DIV_CNT_W-1:0] ratio_m1;
    logic                 hit;

    // last count of a half period
    assign ratio_m1 = (DIV_CNT_W'(1) << div_ratio_i) - 1'b1;
    assign hit      = (cnt_q == ratio_m1);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            cnt_q <= '0;
        end else if (restart_i || !en_i) begin
            cnt_q <= '0;  // full first half period
        end else if (hit) begin
            cnt_q <= '0;
        end else begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    assign tick_o = en_i && hit;

endmodule

// ==== spi_ctrl_fsm.sv ====
/*
 transfer FSM, SCLK edge counter and SCLK register,
 configuration latch and edge role decode
*/
`timescale 1ns/1ns

module spi_ctrl_fsm (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    input  logic                          start_i,
    input  logic                          tick_i,
    input  logic                          msb_first_i,
    input  logic [1:0]                    cp_mode_i,     // [1] CPOL, [0] CPHA
    input  spi_pkg::data_width_e          data_width_i,
    input  logic [spi_pkg::DIV_SEL_W-1:0] div_ratio_i,
    output logic                          load_o,
    output logic                          shift_o,
    output logic                          sample_o,
    output logic                          restart_o,
    output logic                          busy_o,
    output spi_pkg::data_width_e          width_o,
    output logic                          msb_first_o,
    output logic [spi_pkg::DIV_SEL_W-1:0] div_ratio_o,
    output logic                          idle_o,
    output logic                          data_valid_o,
    output logic                          spi_sclk_o
);

    spi_pkg::state_e                  state_q, state_d;
    logic [spi_pkg::EDGE_CNT_W-1:0]   edge_cnt_q;
    logic [spi_pkg::EDGE_CNT_W-1:0]   edge_total;
    logic                             cpol_q, cpha_q;
    logic                             msb_first_q;
    spi_pkg::data_width_e             width_q;
    logic [spi_pkg::DIV_SEL_W-1:0]    div_ratio_q;
    logic                             sclk_q;
    logic                             data_valid_q;
    logic                             accept;
    logic                             edge_tick;
    logic                             last_edge;

    assign accept    = start_i && (state_q == spi_pkg::S_IDLE);
    assign edge_tick = tick_i && (state_q == spi_pkg::S_DATA);

    // two edges per bit
    always_comb begin
        case (width_q)
            spi_pkg::W8:  edge_total = spi_pkg::EDGE_CNT_W'(16);
            spi_pkg::W16: edge_total = spi_pkg::EDGE_CNT_W'(32);
            spi_pkg::W24: edge_total = spi_pkg::EDGE_CNT_W'(48);
            default:      edge_total = spi_pkg::EDGE_CNT_W'(64);
        endcase
    end

    assign last_edge = (edge_cnt_q == edge_total - 1'b1);

    always_comb begin
        state_d = state_q;
        case (state_q)
            spi_pkg::S_IDLE: if (start_i) state_d = spi_pkg::S_DATA;
            spi_pkg::S_DATA: if (tick_i && last_edge) state_d = spi_pkg::S_END;
            spi_pkg::S_END:  if (tick_i) state_d = spi_pkg::S_IDLE;
            default:         state_d = spi_pkg::S_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q      <= spi_pkg::S_IDLE;
            edge_cnt_q   <= '0;
            sclk_q       <= 1'b0;
            data_valid_q <= 1'b0;
            cpol_q       <= 1'b0;
            cpha_q       <= 1'b0;
            msb_first_q  <= 1'b1;
            width_q      <= spi_pkg::W8;
            div_ratio_q  <= '0;
        end else begin
            state_q      <= state_d;
            data_valid_q <= tick_i && (state_q == spi_pkg::S_END);
            if (accept) begin
                cpol_q      <= cp_mode_i[1];
                cpha_q      <= cp_mode_i[0];
                msb_first_q <= msb_first_i;
                width_q     <= data_width_i;
                div_ratio_q <= div_ratio_i;
                edge_cnt_q  <= '0;
                sclk_q      <= cp_mode_i[1];  // rest level of the new mode
            end else if (edge_tick) begin
                edge_cnt_q <= edge_cnt_q + 1'b1;
                sclk_q     <= ~sclk_q;
            end
        end
    end

    // edge_cnt_q[0] low means the coming edge is odd
    assign sample_o  = edge_tick && (edge_cnt_q[0] == cpha_q);
    assign shift_o   = edge_tick && (edge_cnt_q[0] != cpha_q) && (edge_cnt_q != '0);
    assign load_o    = accept;
    assign restart_o = accept;

    // shift register needs the new setup in the load cycle
    assign width_o     = accept ? data_width_i : width_q;
    assign msb_first_o = accept ? msb_first_i : msb_first_q;
    assign div_ratio_o = div_ratio_q;

    assign busy_o       = (state_q != spi_pkg::S_IDLE);
    assign idle_o       = (state_q == spi_pkg::S_IDLE);
    assign data_valid_o = data_valid_q;
    assign spi_sclk_o   = sclk_q;

endmodule

// ==== spi_shift_reg.sv ====
/*
 transmit and receive shift registers, registered MOSI,
 received word output in the low bits
*/
`timescale 1ns/1ns

module spi_shift_reg (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  logic                       load_i,
    input  logic                       shift_i,
    input  logic                       sample_i,
    input  logic                       msb_first_i,
    input  spi_pkg::data_width_e       width_i,
    input  logic [spi_pkg::XFER_W-1:0] data_i,
    input  logic                       spi_miso_i,
    output logic                       spi_mosi_o,
    output logic [spi_pkg::XFER_W-1:0] data_o
);

    localparam int IDX_W = $clog2(spi_pkg::XFER_W);

    logic [spi_pkg::XFER_W-1:0] tx_q, tx_d;
    logic [spi_pkg::XFER_W-1:0] rx_q, rx_d;
    logic [IDX_W-1:0]           top_idx;
    logic                       mosi_q, mosi_d;

    // 7, 15, 23 or 31
    assign top_idx = IDX_W'({width_i, 3'b111});

    always_comb begin
        tx_d = tx_q;
        if (load_i) begin
            tx_d = data_i;
        end else if (shift_i) begin
            if (msb_first_i) begin
                tx_d = tx_q << 1;
            end else begin
                tx_d = tx_q >> 1;
            end
        end
    end

    assign mosi_d = msb_first_i ? tx_d[top_idx] : tx_d[0];

    // LSB first enters at the top of the word and walks down
    always_comb begin
        rx_d = rx_q;
        if (load_i) begin
            rx_d = '0;
        end else if (sample_i) begin
            if (msb_first_i) begin
                rx_d = {rx_q[spi_pkg::XFER_W-2:0], spi_miso_i};
            end else begin
                rx_d          = rx_q >> 1;
                rx_d[top_idx] = spi_miso_i;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        tx_q <= tx_d;
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rx_q   <= '0;
            mosi_q <= 1'b0;
        end else begin
            rx_q <= rx_d;
            if (load_i || shift_i) begin
                mosi_q <= mosi_d;  // changes with SCLK
            end
        end
    end

    assign spi_mosi_o = mosi_q;
    assign data_o     = rx_q;

endmodule

// ==== spi_master_top.sv ====
/*
 single-lane SPI master, divider, control FSM and shift register
*/
`timescale 1ns/1ns

module spi_master_top #(
    parameter int DIV_CNT_W = 8
) (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    input  logic                          start_i,
    input  logic [1:0]                    cp_mode_i,
    input  spi_pkg::data_width_e          data_width_i,
    input  logic [spi_pkg::XFER_W-1:0]    data_i,
    input  logic [spi_pkg::DIV_SEL_W-1:0] div_ratio_i,
    input  logic                          msb_first_i,
    output logic [spi_pkg::XFER_W-1:0]    data_o,
    output logic                          idle_o,
    output logic                          data_valid_o,
    output logic                          spi_sclk_o,
    output logic                          spi_mosi_o,
    input  logic                          spi_miso_i
);

    logic                          tick;
    logic                          load;
    logic                          shift;
    logic                          sample;
    logic                          restart;
    logic                          busy;
    logic                          msb_first;
    spi_pkg::data_width_e          width;
    logic [spi_pkg::DIV_SEL_W-1:0] div_ratio;

    spi_clk_div #(
        .DIV_CNT_W(DIV_CNT_W)
    ) i_clk_div (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .restart_i  (restart),
        .en_i       (busy),
        .div_ratio_i(div_ratio),
        .tick_o     (tick)
    );

    spi_ctrl_fsm i_ctrl_fsm (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .start_i     (start_i),
        .tick_i      (tick),
        .msb_first_i (msb_first_i),
        .cp_mode_i   (cp_mode_i),
        .data_width_i(data_width_i),
        .div_ratio_i (div_ratio_i),
        .load_o      (load),
        .shift_o     (shift),
        .sample_o    (sample),
        .restart_o   (restart),
        .busy_o      (busy),
        .width_o     (width),
        .msb_first_o (msb_first),
        .div_ratio_o (div_ratio),
        .idle_o      (idle_o),
        .data_valid_o(data_valid_o),
        .spi_sclk_o  (spi_sclk_o)
    );

    spi_shift_reg i_shift_reg (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .load_i     (load),
        .shift_i    (shift),
        .sample_i   (sample),
        .msb_first_i(msb_first),
        .width_i    (width),
        .data_i     (data_i),
        .spi_miso_i (spi_miso_i),
        .spi_mosi_o (spi_mosi_o),
        .data_o     (data_o)
    );

endmodule

// ==== spi_master_checker.sv ====
/*
 protocol assertions on the SPI master outputs, bound into the top level
*/
`timescale 1ns/1ns

module spi_master_checker (
    input logic            clk_i,
    input logic            rst_ni,
    input logic            start_i,
    input logic            idle_i,
    input logic            data_valid_i,
    input logic            sclk_i,
    input logic            cpol_i,
    input spi_pkg::state_e state_i
);

    a_valid_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
        data_valid_i |=> !data_valid_i)
        else $error("data_valid_o held for more than one cycle");

    // valid and the return to idle are the same event
    a_valid_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
        data_valid_i |-> (idle_i && !$past(idle_i)))
        else $error("data_valid_o without a rise of idle_o");

    a_idle_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (idle_i && !$past(idle_i)) |-> data_valid_i)
        else $error("idle_o rose without data_valid_o");

    a_sclk_rest: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (state_i == spi_pkg::S_IDLE) |-> (sclk_i == cpol_i))
        else $error("SCLK away from CPOL while idle");

    a_start_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (start_i && idle_i) |=> !idle_i)
        else $error("idle_o still high after an accepted start");

endmodule

bind spi_master_top spi_master_checker i_checker (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .start_i     (start_i),
    .idle_i      (idle_o),
    .data_valid_i(data_valid_o),
    .sclk_i      (spi_sclk_o),
    .cpol_i      (i_ctrl_fsm.cpol_q),
    .state_i     (i_ctrl_fsm.state_q)
);

// ==== spi_master_tb.sv ====
/*
 SPI master testbench with clock, SPI slave model, reference function,
 compare tasks and watchdog
*/
`timescale 1ns/1ns

module spi_master_tb;

    localparam int IDX_W       = $clog2(spi_pkg::XFER_W);
    localparam int N_XFER      = 19;
    localparam int MAX_DIV     = (1 << spi_pkg::DIV_SEL_W) - 1;
    localparam int WATCHDOG_NS = N_XFER * 70 * (1 << MAX_DIV) * 10 * 2;  // x2 margin

    logic                          clk_i;
    logic                          rst_ni;
    logic                          start;
    logic [1:0]                    cp_mode;
    spi_pkg::data_width_e          data_width;
    logic [spi_pkg::XFER_W-1:0]    data_word;
    logic [spi_pkg::DIV_SEL_W-1:0] div_ratio;
    logic                          msb_first;
    logic                          spi_miso = 1'b0;
    logic [spi_pkg::XFER_W-1:0]    rx_data;
    logic                          idle;
    logic                          data_valid;
    logic                          spi_sclk;
    logic                          spi_mosi;

    // slave model
    logic [spi_pkg::XFER_W-1:0] slave_word;
    logic [spi_pkg::XFER_W-1:0] slv_word;
    logic [spi_pkg::XFER_W-1:0] slv_rx;
    logic                       slv_cpha;
    logic                       slv_msb;
    int                         slv_bits;
    int                         slv_idx;
    int                         slv_samples;
    int                         slv_edges;
    logic                       slv_prev_idle = 1'b1;
    logic                       slv_prev_sclk = 1'b0;

    logic [spi_pkg::XFER_W-1:0] exp_rx_q[$];
    logic [spi_pkg::XFER_W-1:0] exp_tx_q[$];
    string                      test_name;
    integer                     seed;
    int                         mismatch_cnt;
    int                         fail_cnt;
    int                         valid_cnt;

    spi_master_top #(
        .DIV_CNT_W(8)
    ) i_spi_master_top (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .start_i     (start),
        .cp_mode_i   (cp_mode),
        .data_width_i(data_width),
        .data_i      (data_word),
        .div_ratio_i (div_ratio),
        .msb_first_i (msb_first),
        .data_o      (rx_data),
        .idle_o      (idle),
        .data_valid_o(data_valid),
        .spi_sclk_o  (spi_sclk),
        .spi_mosi_o  (spi_mosi),
        .spi_miso_i  (spi_miso)
    );

    function automatic int width_bits(spi_pkg::data_width_e w);
        case (w)
            spi_pkg::W8:  return 8;
            spi_pkg::W16: return 16;
            spi_pkg::W24: return 24;
            default:      return 32;
        endcase
    endfunction

    // word position of the k-th bit on the wire
    function automatic logic [IDX_W-1:0] bit_pos(int k, int nbits, logic msb);
        return IDX_W'(msb ? nbits - 1 - k : k);
    endfunction

    // each bit lands where it left and only the low width bits come back
    function automatic logic [spi_pkg::XFER_W-1:0] expected_word(
        logic [spi_pkg::XFER_W-1:0] word, spi_pkg::data_width_e w, logic msb);
        logic [spi_pkg::XFER_W-1:0] res;
        res = '0;
        for (int k = 0; k < width_bits(w); k++) begin
            res[bit_pos(k, width_bits(w), msb)] = word[bit_pos(k, width_bits(w), msb)];
        end
        return res;
    endfunction

    task automatic check_word(input string name, input logic [spi_pkg::XFER_W-1:0] exp,
                              input logic [spi_pkg::XFER_W-1:0] act);
        if (act !== exp) begin
            $display("mismatch %s: expected %h, actual %h", name, exp, act);
            mismatch_cnt++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("mismatch %s: expected %b, actual %b", name, exp, act);
            mismatch_cnt++;
        end
    endtask

    task automatic next_cycle();
        @(posedge clk_i);
        #1;
    endtask

    task automatic run_transfer(input string name, input logic [1:0] mode,
                                input spi_pkg::data_width_e width,
                                input logic [spi_pkg::DIV_SEL_W-1:0] div,
                                input logic msb, input logic busy_start);
        logic [spi_pkg::XFER_W-1:0] tx_word;
        int                         limit;
        int                         cycles;
        int                         valid_seen;
        tx_word    = $random(seed);
        slave_word = $random(seed);
        exp_rx_q.push_back(expected_word(slave_word, width, msb));
        exp_tx_q.push_back(expected_word(tx_word, width, msb));
        test_name  = name;
        cp_mode    = mode;
        data_width = width;
        div_ratio  = div;
        msb_first  = msb;
        data_word  = tx_word;
        start      = 1'b1;
        next_cycle();
        start      = 1'b0;
        check_flag({name, " idle_o after start"}, 1'b0, idle);
        valid_seen = valid_cnt;
        limit      = 70 * (1 << div);
        if (busy_start) begin
            repeat (3) next_cycle();
            data_word = ~tx_word;  // must not reach the wire
            cp_mode   = ~mode;
            start     = 1'b1;
            next_cycle();
            start     = 1'b0;
        end
        cycles = 0;
        while (!data_valid && cycles < limit) begin
            next_cycle();
            cycles++;
        end
        if (!data_valid) begin
            $display("%s: no data_valid_o within %0d cycles of the start", name, limit);
            fail_cnt++;
            exp_rx_q.delete();
            exp_tx_q.delete();
        end else begin
            check_flag({name, " idle_o with data_valid_o"}, 1'b1, idle);
            next_cycle();
            check_flag({name, " data_valid_o after pulse"}, 1'b0, data_valid);
            check_flag({name, " SCLK rest level"}, mode[1], spi_sclk);
        end
        if (busy_start) begin
            repeat (limit) next_cycle();
            if (valid_cnt - valid_seen != 1) begin
                $display("%s: %0d data_valid_o pulses where one was due",
                         name, valid_cnt - valid_seen);
                fail_cnt++;
            end
        end
    endtask

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    // shifts MISO and captures MOSI on the edges its mode assigns
    always begin
        @(posedge clk_i);
        #1;
        if (slv_prev_idle && !idle) begin
            slv_edges   = 0;
            slv_idx     = 0;
            slv_samples = 0;
            slv_rx      = '0;
            slv_word    = slave_word;
            slv_cpha    = cp_mode[0];
            slv_msb     = msb_first;
            slv_bits    = width_bits(data_width);
            spi_miso    = slv_word[bit_pos(0, slv_bits, slv_msb)];  // first bit early
        end else if (!idle && spi_sclk != slv_prev_sclk) begin
            slv_edges = slv_edges + 1;
            if ((slv_edges % 2 == 1) != slv_cpha) begin
                if (slv_samples < slv_bits) begin
                    slv_rx[bit_pos(slv_samples, slv_bits, slv_msb)] = spi_mosi;
                end
                slv_samples = slv_samples + 1;
            end else if (slv_edges > 1) begin
                slv_idx = slv_idx + 1;
                if (slv_idx < slv_bits) begin
                    spi_miso = slv_word[bit_pos(slv_idx, slv_bits, slv_msb)];
                end
            end
        end
        slv_prev_idle = idle;
        slv_prev_sclk = spi_sclk;
    end

    always @(negedge clk_i) begin
        if (rst_ni && data_valid) begin
            valid_cnt++;
            if (exp_rx_q.size() == 0) begin
                $display("%s: data_valid_o with no transfer outstanding", test_name);
                fail_cnt++;
            end else begin
                check_word({test_name, " data_o"}, exp_rx_q.pop_front(), rx_data);
                check_word({test_name, " slave rx"}, exp_tx_q.pop_front(), slv_rx);
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, transfers did not finish", WATCHDOG_NS);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        seed         = 32'h4615_f3fa;
        rst_ni       = 1'b0;
        start        = 1'b0;
        cp_mode      = 2'd0;
        data_width   = spi_pkg::W8;
        data_word    = '0;
        div_ratio    = '0;
        msb_first    = 1'b1;
        slave_word   = '0;
        mismatch_cnt = 0;
        fail_cnt     = 0;
        valid_cnt    = 0;
        test_name    = "reset";
        repeat (3) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;
        check_flag("reset idle_o", 1'b1, idle);
        check_flag("reset data_valid_o", 1'b0, data_valid);
        check_flag("reset SCLK", 1'b0, spi_sclk);

        for (int m = 0; m < 4; m++) begin
            run_transfer($sformatf("mode %0d W8", m), 2'(m), spi_pkg::W8, 3'd1, 1'b1, 1'b0);
        end
        for (int w = 0; w < 8; w++) begin
            run_transfer($sformatf("width %0d msb %0d", w / 2, w % 2), 2'd0,
                         spi_pkg::data_width_e'(2'(w / 2)), 3'd0, 1'(w % 2), 1'b0);
        end
        run_transfer("lsb W8 mode 1", 2'd1, spi_pkg::W8, 3'd2, 1'b0, 1'b0);
        run_transfer("lsb W24 mode 2", 2'd2, spi_pkg::W24, 3'd2, 1'b0, 1'b0);
        run_transfer("lsb W32 mode 3", 2'd3, spi_pkg::W32, 3'd1, 1'b0, 1'b0);
        run_transfer("div 0 mode 3", 2'd3, spi_pkg::W8, 3'd0, 1'b1, 1'b0);
        run_transfer("div 3 mode 0", 2'd0, spi_pkg::W16, 3'd3, 1'b0, 1'b0);
        run_transfer("div 7 mode 2", 2'd2, spi_pkg::W8, 3'd7, 1'b1, 1'b0);
        run_transfer("start while busy", 2'd1, spi_pkg::W16, 3'd2, 1'b1, 1'b1);

        repeat (5) next_cycle();
        $display("summary: %0d mismatches, %0d other failures, %0d valid pulses",
                 mismatch_cnt, fail_cnt, valid_cnt);
        if (mismatch_cnt == 0 && fail_cnt == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
spi_pkg.sv
spi_clk_div.sv
spi_ctrl_fsm.sv
spi_shift_reg.sv
spi_master_top.sv
spi_master_checker.sv
spi_master_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run with Verilator, the log decides pass or fail
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -f compile.f --top-module spi_master_tb \
    -o spi_master_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/spi_master_sim > sim.log 2>&1 || echo "TEST FAILED" >> sim.log
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1 || exit 0
